// File: sim.f
common/epu_pkg.sv
logic/msr_decode.sv
logic/exc_commit.sv
logic/epu_irqc.sv
logic/epu_tsc.sv
logic/ex_epu.sv
sim/epu_checker.sv
sim/ex_epu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= ex_epu_tb
FLIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/ex_epu_tb.sv
`timescale 1ns/1ns

module ex_epu_tb;
   import epu_pkg::*;

   localparam int CLK_PERIOD = 8;
   localparam logic [31:0] RM = 32'h10;
   localparam logic [31:0] IRE = 32'h20;

   typedef enum {C_NONE, C_READ, C_FLUSH, C_IRQ, C_TSC, C_TSR, C_TCRW} chk_e;

   typedef struct {
      logic [8*12-1:0] name;
      epu_op_e op;
      logic [DW-1:0] addr;
      logic [DW-1:0] wdat;
      logic [PC_W-1:0] pc;
      logic [PC_W-1:0] npc;
      logic [NUM_IRQ-1:0] irq;
      logic sq;
      int hold;
      chk_e chk;
      logic [DW-1:0] exp;
   } row_t;

   logic clk = 1'b0;
   logic rst_n;
   logic p_ce;
   logic squash;
   epu_req_t req;
   logic [NUM_IRQ-1:0] irqs;
   logic [DW-1:0] epu_dout;
   logic epu_dout_valid;
   logic exc_flush;
   logic [PC_W-1:0] exc_flush_tgt;
   logic irq_async;
   logic tsc_irq;

   logic [8*12-1:0] test_name;
   logic chk_read;
   logic [DW-1:0] exp_dout;
   logic exp_flush;
   logic [PC_W-1:0] exp_tgt;
   logic chk_irq;
   logic chk_tsc;
   logic exp_lvl;
   int errors;
   int flushes;

   // Reference count of clocks since reset, matches TSR while it is never written
   logic [DW-1:0] tsr_model;
   row_t rows[$];
   int n_rows = 0;
   integer seed = 67230;

   always #(CLK_PERIOD/2) clk = ~clk;

   always @(posedge clk)
   begin
      if (!rst_n)
         tsr_model <= '0;
      else
         tsr_model <= tsr_model + 1'b1;
   end

   ex_epu ex_epu_i (.clk(clk), .rst_n(rst_n), .p_ce(p_ce), .flush(squash), .req(req),
                    .irqs(irqs), .epu_dout(epu_dout), .epu_dout_valid(epu_dout_valid),
                    .exc_flush(exc_flush), .exc_flush_tgt(exc_flush_tgt),
                    .irq_async(irq_async), .tsc_irq(tsc_irq));

   epu_checker checker_i (.clk(clk), .rst_n(rst_n), .p_ce(p_ce), .epu_dout(epu_dout),
                          .epu_dout_valid(epu_dout_valid), .exc_flush(exc_flush),
                          .exc_flush_tgt(exc_flush_tgt), .irq_async(irq_async),
                          .tsc_irq(tsc_irq), .test_name(test_name), .chk_read(chk_read),
                          .exp_dout(exp_dout), .exp_flush(exp_flush), .exp_tgt(exp_tgt),
                          .chk_irq(chk_irq), .chk_tsc(chk_tsc), .exp_lvl(exp_lvl),
                          .errors(errors), .flushes(flushes));

   function automatic logic [DW-1:0] msr_addr(input logic [3:0] b, input int o);
      return (32'(b) << MSR_BANK_OFF_AW) | (32'd1 << o);
   endfunction

   task automatic add_row(input logic [8*12-1:0] name, input epu_op_e op,
                          input logic [DW-1:0] addr, input logic [DW-1:0] wdat,
                          input logic [PC_W-1:0] pc, input logic [PC_W-1:0] npc,
                          input logic [NUM_IRQ-1:0] irq, input logic sq, input int hold,
                          input chk_e chk, input logic [DW-1:0] exp);
      row_t r;
      r = '{name, op, addr, wdat, pc, npc, irq, sq, hold, chk, exp};
      rows.push_back(r);
   endtask

   task automatic build_table();
      logic [DW-1:0] r_epc;
      logic [DW-1:0] r_elsa;
      logic [DW-1:0] r_epsr;
      logic [DW-1:0] psr_w;
      logic [DW-1:0] psr_exc;
      r_epc = $random(seed);
      r_elsa = $random(seed);
      r_epsr = $random(seed) & 32'h3ff;
      // Handler PSR keeps the mode bits but turns interrupts off
      psr_w = 32'h0c0 | IRE | RM;
      psr_exc = (psr_w & ~IRE) | RM;
      add_row("rst_psr", OP_RMSR, msr_addr(BANK_PS, OFF_PSR), 0, 0, 0, 0, 0, 0, C_READ,
              32'(PSR_RESET));
      add_row("rst_cpuid", OP_RMSR, msr_addr(BANK_PS, OFF_CPUID), 0, 0, 0, 0, 0, 0, C_READ,
              CPUID_VALUE);
      add_row("rst_imr", OP_RMSR, msr_addr(BANK_IRQC, OFF_IMR), 0, 0, 0, 0, 0, 0, C_READ, '1);
      add_row("unmapped", OP_RMSR, msr_addr(4'd3, 1), 0, 0, 0, 0, 0, 0, C_READ, 0);
      add_row("wr_epc", OP_WMSR, msr_addr(BANK_PS, OFF_EPC), r_epc, 0, 0, 0, 0, 0, C_NONE, 0);
      add_row("wr_elsa", OP_WMSR, msr_addr(BANK_PS, OFF_ELSA), r_elsa, 0, 0, 0, 0, 0, C_NONE, 0);
      add_row("wr_epsr", OP_WMSR, msr_addr(BANK_PS, OFF_EPSR), r_epsr, 0, 0, 0, 0, 0, C_NONE, 0);
      add_row("rd_epc", OP_RMSR, msr_addr(BANK_PS, OFF_EPC), 0, 0, 0, 0, 0, 0, C_READ, r_epc);
      add_row("rd_elsa", OP_RMSR, msr_addr(BANK_PS, OFF_ELSA), 0, 0, 0, 0, 0, 0, C_READ, r_elsa);
      add_row("rd_epsr", OP_RMSR, msr_addr(BANK_PS, OFF_EPSR), 0, 0, 0, 0, 0, 0, C_READ, r_epsr);
      add_row("wr_psr", OP_WMSR, msr_addr(BANK_PS, OFF_PSR), psr_w, 30'h20, 30'h21, 0, 0, 0,
              C_FLUSH, 32'h21);
      add_row("rd_psr", OP_RMSR, msr_addr(BANK_PS, OFF_PSR), 0, 0, 0, 0, 0, 0, C_READ, psr_w);
      add_row("syscall", OP_ESYSCALL, 0, 0, 30'h40, 30'h41, 0, 0, 0, C_FLUSH, VEC_SYSCALL >> 2);
      add_row("sc_epc", OP_RMSR, msr_addr(BANK_PS, OFF_EPC), 0, 0, 0, 0, 0, 0, C_READ,
              32'h41 << 2);
      add_row("sc_epsr", OP_RMSR, msr_addr(BANK_PS, OFF_EPSR), 0, 0, 0, 0, 0, 0, C_READ, psr_w);
      add_row("sc_psr", OP_RMSR, msr_addr(BANK_PS, OFF_PSR), 0, 0, 0, 0, 0, 0, C_READ, psr_exc);
      add_row("eret_sc", OP_ERET, 0, 0, 0, 0, 0, 0, 0, C_FLUSH, 32'h41);
      add_row("eret_psr", OP_RMSR, msr_addr(BANK_PS, OFF_PSR), 0, 0, 0, 0, 0, 0, C_READ, psr_w);
      add_row("einsn", OP_EINSN, 0, 0, 30'h90, 30'h91, 0, 0, 0, C_FLUSH, VEC_INSN >> 2);
      add_row("in_elsa", OP_RMSR, msr_addr(BANK_PS, OFF_ELSA), 0, 0, 0, 0, 0, 0, C_READ,
              32'h90 << 2);
      add_row("in_epc", OP_RMSR, msr_addr(BANK_PS, OFF_EPC), 0, 0, 0, 0, 0, 0, C_READ,
              32'h90 << 2);
      add_row("in_epsr", OP_RMSR, msr_addr(BANK_PS, OFF_EPSR), 0, 0, 0, 0, 0, 0, C_READ, psr_w);
      add_row("in_psr", OP_RMSR, msr_addr(BANK_PS, OFF_PSR), 0, 0, 0, 0, 0, 0, C_READ, psr_exc);
      add_row("eret_in", OP_ERET, 0, 0, 0, 0, 0, 0, 0, C_FLUSH, 32'h90);
      // Back-pressure holds the commit for several cycles
      add_row("sc_hold", OP_ESYSCALL, 0, 0, 30'h50, 30'h51, 0, 0, 5, C_FLUSH, VEC_SYSCALL >> 2);
      add_row("eret_hold", OP_ERET, 0, 0, 0, 0, 0, 0, 0, C_FLUSH, 32'h51);
      add_row("sq_write", OP_WMSR, msr_addr(BANK_PS, OFF_EPC), 32'hdead, 0, 0, 0, 1, 0, C_NONE, 0);
      add_row("sq_read", OP_RMSR, msr_addr(BANK_PS, OFF_PSR), 0, 0, 0, 0, 1, 0, C_NONE, 0);
      add_row("sq_sc", OP_ESYSCALL, 0, 0, 30'h60, 30'h61, 0, 1, 0, C_NONE, 0);
      add_row("sq_epc", OP_RMSR, msr_addr(BANK_PS, OFF_EPC), 0, 0, 0, 0, 0, 0, C_READ,
              32'h51 << 2);
      add_row("imr_clr", OP_WMSR, msr_addr(BANK_IRQC, OFF_IMR), 0, 0, 0, 0, 0, 0, C_NONE, 0);
      add_row("irq_on", OP_NONE, 0, 0, 0, 0, 8'h04, 0, 0, C_IRQ, 1);
      add_row("imr_set", OP_WMSR, msr_addr(BANK_IRQC, OFF_IMR), '1, 0, 0, 8'h04, 0, 0, C_NONE, 0);
      add_row("irq_off", OP_NONE, 0, 0, 0, 0, 8'h04, 0, 0, C_IRQ, 0);
      add_row("eirq", OP_EIRQ, 0, 0, 30'h70, 30'h71, 0, 0, 0, C_FLUSH, VEC_IRQ >> 2);
      add_row("tsr_a", OP_RMSR, msr_addr(BANK_TSC, OFF_TSR), 0, 0, 0, 0, 0, 0, C_TSR, 0);
      add_row("tsr_b", OP_RMSR, msr_addr(BANK_TSC, OFF_TSR), 0, 0, 0, 0, 0, 0, C_TSR, 0);
      add_row("tcr_arm", OP_WMSR, msr_addr(BANK_TSC, OFF_TCR), 0, 0, 0, 0, 0, 0, C_TCRW, 0);
      add_row("tsc_on", OP_NONE, 0, 0, 0, 0, 0, 0, 0, C_TSC, 1);
      add_row("tcr_clr", OP_WMSR, msr_addr(BANK_TSC, OFF_TCR), 0, 0, 0, 0, 0, 0, C_NONE, 0);
      add_row("tsc_off", OP_NONE, 0, 0, 0, 0, 0, 0, 0, C_TSC, 0);
   endtask

   task automatic run_row(input row_t r);
      int base;
      int lim;
      logic [DW-1:0] wd;
      logic lvl;
      wd = r.wdat;
      if (r.chk == C_TCRW)
         wd = (32'd1 << TCR_EN_BIT) | (32'd1 << TCR_IE_BIT) |
              ((tsr_model + 32'd11) & ((32'd1 << TCR_CNT_W) - 1));
      irqs <= r.irq;
      test_name <= r.name;
      if (r.op != OP_NONE)
      begin
         req <= '{valid: 1'b1, op: r.op, pc: r.pc, npc: r.npc, operand1: r.addr,
                  operand2: wd, imm: '0};
         squash <= r.sq;
         chk_read <= (r.chk == C_READ) || (r.chk == C_TSR);
         // TSR moves to its next count at this edge
         exp_dout <= (r.chk == C_TSR) ? tsr_model + 1'b1 : r.exp;
         exp_flush <= (r.chk == C_FLUSH);
         exp_tgt <= r.exp[PC_W-1:0];
         base = flushes;
         @(posedge clk);
         req.valid <= 1'b0;
         squash <= 1'b0;
         chk_read <= 1'b0;
         if (r.hold > 0)
         begin
            p_ce <= 1'b0;
            repeat (r.hold) @(posedge clk);
            p_ce <= 1'b1;
         end
         if (r.chk == C_FLUSH)
         begin
            for (int w = 0; w < 20 && flushes == base; w++)
               @(posedge clk);
            exp_flush <= 1'b0;
         end
         @(posedge clk);
      end
      else
      begin
         exp_lvl <= r.exp[0];
         lim = (r.chk == C_IRQ) ? 2 : 12;
         for (int w = 0; w < lim; w++)
         begin
            @(negedge clk);
            lvl = (r.chk == C_IRQ) ? irq_async : tsc_irq;
            if (lvl == r.exp[0])
               break;
         end
         @(posedge clk);
         chk_irq <= (r.chk == C_IRQ);
         chk_tsc <= (r.chk == C_TSC);
         @(posedge clk);
         chk_irq <= 1'b0;
         chk_tsc <= 1'b0;
      end
      @(posedge clk);
   endtask

   initial
   begin
      rst_n = 1'b0;
      p_ce = 1'b1;
      squash = 1'b0;
      req = '0;
      irqs = '0;
      test_name = "reset";
      chk_read = 1'b0;
      exp_dout = '0;
      exp_flush = 1'b0;
      exp_tgt = '0;
      chk_irq = 1'b0;
      chk_tsc = 1'b0;
      exp_lvl = 1'b0;
      build_table();
      n_rows = rows.size();
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      foreach (rows[i])
         run_row(rows[i]);
      repeat (4) @(posedge clk);
      $display("Checks done with %0d errors over %0d tests", errors, n_rows);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   initial
   begin
      wait (n_rows > 0);
      #(CLK_PERIOD * (n_rows * 20 + 100));
      $display("Timeout, the test sequence did not complete in time");
      $display("Simulation failed");
      $finish;
   end

endmodule

// File: sim/epu_checker.sv
`timescale 1ns/1ns

module epu_checker (
   input  logic clk,
   input  logic rst_n,
   input  logic p_ce,
   input  logic [epu_pkg::DW-1:0] epu_dout,
   input  logic epu_dout_valid,
   input  logic exc_flush,
   input  logic [epu_pkg::PC_W-1:0] exc_flush_tgt,
   input  logic irq_async,
   input  logic tsc_irq,
   input  logic [8*12-1:0] test_name,
   input  logic chk_read,
   input  logic [epu_pkg::DW-1:0] exp_dout,
   input  logic exp_flush,
   input  logic [epu_pkg::PC_W-1:0] exp_tgt,
   input  logic chk_irq,
   input  logic chk_tsc,
   input  logic exp_lvl,
   output int errors,
   output int flushes
);
   import epu_pkg::*;

   logic armed;
   logic seen;

   initial
   begin
      errors = 0;
      flushes = 0;
      armed = 1'b0;
      seen = 1'b0;
   end

   // Sample on the falling edge, away from the DUT update
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         if (epu_dout_valid && !chk_read)
         begin
            $display("%s: read data valid when no read was expected", test_name);
            errors = errors + 1;
         end
         if (chk_read && !epu_dout_valid)
         begin
            $display("%s: read data valid missing", test_name);
            errors = errors + 1;
         end
         if (chk_read && epu_dout_valid && epu_dout !== exp_dout)
         begin
            $display("Mismatch %s dout expected %h actual %h", test_name, exp_dout, epu_dout);
            errors = errors + 1;
         end
         if (exc_flush)
         begin
            flushes = flushes + 1;
            if (!exp_flush || seen || !p_ce)
            begin
               $display("%s: unexpected extra flush", test_name);
               errors = errors + 1;
            end
            else if (exc_flush_tgt !== exp_tgt)
            begin
               $display("Mismatch %s flush target expected %h actual %h", test_name, exp_tgt,
                        exc_flush_tgt);
               errors = errors + 1;
            end
            seen = 1'b1;
         end
         if (armed && !exp_flush && !seen)
         begin
            $display("%s: expected flush never came", test_name);
            errors = errors + 1;
         end
         if (!exp_flush)
            seen = 1'b0;
         armed = exp_flush;
         if (chk_irq && irq_async !== exp_lvl)
         begin
            $display("Mismatch %s irq_async expected %b actual %b", test_name, exp_lvl, irq_async);
            errors = errors + 1;
         end
         if (chk_tsc && tsc_irq !== exp_lvl)
         begin
            $display("Mismatch %s tsc_irq expected %b actual %b", test_name, exp_lvl, tsc_irq);
            errors = errors + 1;
         end
      end
   end

endmodule

// File: logic/ex_epu.sv
`timescale 1ns/1ns

module ex_epu (
   input  logic clk,
   input  logic rst_n,
   input  logic p_ce,
   input  logic flush,
   input  epu_pkg::epu_req_t req,
   input  logic [epu_pkg::NUM_IRQ-1:0] irqs,
   output logic [epu_pkg::DW-1:0] epu_dout,
   output logic epu_dout_valid,
   output logic exc_flush,
   output logic [epu_pkg::PC_W-1:0] exc_flush_tgt,
   output logic irq_async,
   output logic tsc_irq
);
   import epu_pkg::*;

   psr_t psr;
   psr_t epsr;
   logic [DW-1:0] epc;
   logic [DW-1:0] elsa;
   logic [DW-1:0] imr;
   logic [DW-1:0] irr;
   logic [DW-1:0] tsr;
   logic [DW-1:0] tcr;
   msr_view_t view;
   commit_t commit;
   msr_wr_t wr;

   assign view = '{psr: {{(DW-PSR_DW){1'b0}}, psr}, epsr: {{(DW-PSR_DW){1'b0}}, epsr},
                   epc: epc, elsa: elsa, imr: imr, irr: irr, tsr: tsr, tcr: tcr};

   msr_decode u_decode (.clk(clk), .rst_n(rst_n), .p_ce(p_ce), .flush(flush), .req(req),
                        .view(view), .epu_dout(epu_dout), .epu_dout_valid(epu_dout_valid),
                        .commit(commit), .wr(wr));

   exc_commit u_commit (.clk(clk), .rst_n(rst_n), .p_ce(p_ce), .commit(commit), .psr(psr),
                        .epsr(epsr), .epc(epc), .elsa(elsa), .exc_flush(exc_flush),
                        .exc_flush_tgt(exc_flush_tgt));

   epu_irqc u_irqc (.clk(clk), .rst_n(rst_n), .irqs(irqs), .psr_ire(psr.ire), .wr(wr),
                    .imr(imr), .irr(irr), .irq_async(irq_async));

   epu_tsc u_tsc (.clk(clk), .rst_n(rst_n), .wr(wr), .tsr(tsr), .tcr(tcr), .tsc_irq(tsc_irq));

endmodule

// File: logic/epu_tsc.sv
`timescale 1ns/1ns

module epu_tsc (
   input  logic clk,
   input  logic rst_n,
   input  epu_pkg::msr_wr_t wr,
   output logic [epu_pkg::DW-1:0] tsr,
   output logic [epu_pkg::DW-1:0] tcr,
   output logic tsc_irq
);
   import epu_pkg::*;

   logic hit;

   // Free running, software may reload it
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         tsr <= '0;
      else if (wr.tsr_we)
         tsr <= wr.wdat;
      else
         tsr <= tsr + 1'b1;
   end

   assign hit = tcr[TCR_EN_BIT] & (tsr[TCR_CNT_W-1:0] == tcr[TCR_CNT_W-1:0]);

   // Pending is sticky until software rewrites TCR
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         tcr <= '0;
      else if (wr.tcr_we)
         tcr <= wr.wdat;
      else if (hit)
         tcr[TCR_P_BIT] <= 1'b1;
   end

   assign tsc_irq = tcr[TCR_P_BIT] & tcr[TCR_IE_BIT];

   a_pending_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(tcr[TCR_P_BIT]) && !$past(wr.tcr_we) |-> $past(tcr[TCR_EN_BIT]));

endmodule

// File: logic/epu_irqc.sv
`timescale 1ns/1ns

module epu_irqc (
   input  logic clk,
   input  logic rst_n,
   input  logic [epu_pkg::NUM_IRQ-1:0] irqs,
   input  logic psr_ire,
   input  epu_pkg::msr_wr_t wr,
   output logic [epu_pkg::DW-1:0] imr,
   output logic [epu_pkg::DW-1:0] irr,
   output logic irq_async
);
   import epu_pkg::*;

   // Raw lines sampled once without edge detection
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         irr <= '0;
      else
         irr <= {{(DW-NUM_IRQ){1'b0}}, irqs};
   end

   // Everything masked out of reset
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         imr <= '1;
      else if (wr.imr_we)
         imr <= wr.wdat;
   end

   assign irq_async = psr_ire & (|(irr & ~imr));

   // Mask only changes through an MSR write
   a_imr_write_only: assert property (@(posedge clk) disable iff (!rst_n)
      !wr.imr_we |=> $stable(imr));

endmodule

// File: logic/exc_commit.sv
`timescale 1ns/1ns

module exc_commit (
   input  logic clk,
   input  logic rst_n,
   input  logic p_ce,
   input  epu_pkg::commit_t commit,
   output epu_pkg::psr_t psr,
   output epu_pkg::psr_t epsr,
   output logic [epu_pkg::DW-1:0] epc,
   output logic [epu_pkg::DW-1:0] elsa,
   output logic exc_flush,
   output logic [epu_pkg::PC_W-1:0] exc_flush_tgt
);
   import epu_pkg::*;

   logic wmsr;
   logic psr_we;
   logic exc_ent;
   logic eret;

   assign wmsr = p_ce & (commit.op == OP_WMSR);
   assign psr_we = wmsr & (commit.reg_sel == MSR_PSR);
   assign eret = p_ce & (commit.op == OP_ERET);
   assign exc_ent = p_ce & ((commit.op == OP_ESYSCALL) | (commit.op == OP_EINSN) |
                            (commit.op == OP_EIRQ));

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         psr <= psr_t'(PSR_RESET);
      else if (psr_we)
         psr <= psr_t'(commit.wdat[PSR_DW-1:0]);
      else if (exc_ent)
      begin
         // Enter handler in real mode with interrupts off
         psr.rm <= 1'b1;
         psr.ire <= 1'b0;
      end
      else if (eret)
      begin
         psr.rm <= epsr.rm;
         psr.ire <= epsr.ire;
         psr.imme <= epsr.imme;
         psr.dmme <= epsr.dmme;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         epsr <= '0;
         epc <= '0;
         elsa <= '0;
      end
      else
      begin
         if (wmsr && commit.reg_sel == MSR_EPSR)
            epsr <= psr_t'(commit.wdat[PSR_DW-1:0]);
         else if (exc_ent)
            epsr <= psr;
         // Syscall returns past itself while the others retry the faulting insn
         if (wmsr && commit.reg_sel == MSR_EPC)
            epc <= commit.wdat;
         else if (exc_ent)
            epc <= (commit.op == OP_ESYSCALL) ? {commit.nepc, 2'b00} : {commit.epc, 2'b00};
         if (wmsr && commit.reg_sel == MSR_ELSA)
            elsa <= commit.wdat;
         else if (p_ce && commit.op == OP_EINSN)
            elsa <= {commit.epc, 2'b00};
      end
   end

   assign exc_flush = exc_ent | eret | psr_we;

   always_comb
   begin
      case (commit.op)
         OP_ESYSCALL: exc_flush_tgt = VEC_SYSCALL[DW-1:2];
         OP_EINSN: exc_flush_tgt = VEC_INSN[DW-1:2];
         OP_EIRQ: exc_flush_tgt = VEC_IRQ[DW-1:2];
         OP_ERET: exc_flush_tgt = epc[DW-1:2];
         // PSR write refetches from the next insn
         OP_WMSR: exc_flush_tgt = commit.nepc;
         default: exc_flush_tgt = '0;
      endcase
   end

   // Status registers hold while the pipeline is stalled
   a_hold_without_ce: assert property (@(posedge clk) disable iff (!rst_n)
      !p_ce |=> $stable(psr) && $stable(epsr) && $stable(epc) && $stable(elsa));

endmodule

// File: logic/msr_decode.sv
`timescale 1ns/1ns

module msr_decode (
   input  logic clk,
   input  logic rst_n,
   input  logic p_ce,
   input  logic flush,
   input  epu_pkg::epu_req_t req,
   input  epu_pkg::msr_view_t view,
   output logic [epu_pkg::DW-1:0] epu_dout,
   output logic epu_dout_valid,
   output epu_pkg::commit_t commit,
   output epu_pkg::msr_wr_t wr
);
   import epu_pkg::*;

   logic [DW-1:0] addr;
   logic [MSR_BANK_AW-1:0] bank;
   logic [MSR_BANK_OFF_AW-1:0] off;
   msr_reg_e dec_reg;
   logic accept;
   logic wmsr_commit;
   epu_op_e c_op;
   msr_reg_e c_reg;
   logic [DW-1:0] c_wdat;
   logic [PC_W-1:0] c_epc;
   logic [PC_W-1:0] c_nepc;

   assign addr = req.operand1 | {{(DW-15){1'b0}}, req.imm[14:0]};
   assign bank = addr[MSR_BANK_AW+MSR_BANK_OFF_AW-1:MSR_BANK_OFF_AW];
   assign off = addr[MSR_BANK_OFF_AW-1:0];

   // Lowest set offset bit wins within a bank
   always_comb
   begin
      dec_reg = MSR_NONE;
      case (bank)
         BANK_PS:
         begin
            if (off[OFF_PSR])
               dec_reg = MSR_PSR;
            else if (off[OFF_CPUID])
               dec_reg = MSR_CPUID;
            else if (off[OFF_EPSR])
               dec_reg = MSR_EPSR;
            else if (off[OFF_EPC])
               dec_reg = MSR_EPC;
            else if (off[OFF_ELSA])
               dec_reg = MSR_ELSA;
         end
         BANK_IRQC:
         begin
            if (off[OFF_IMR])
               dec_reg = MSR_IMR;
            else if (off[OFF_IRR])
               dec_reg = MSR_IRR;
         end
         BANK_TSC:
         begin
            if (off[OFF_TSR])
               dec_reg = MSR_TSR;
            else if (off[OFF_TCR])
               dec_reg = MSR_TCR;
         end
         default:
            dec_reg = MSR_NONE;
      endcase
   end

   // Read data mux with zero for unmapped addresses
   always_comb
   begin
      case (dec_reg)
         MSR_PSR: epu_dout = view.psr;
         MSR_CPUID: epu_dout = CPUID_VALUE;
         MSR_EPSR: epu_dout = view.epsr;
         MSR_EPC: epu_dout = view.epc;
         MSR_ELSA: epu_dout = view.elsa;
         MSR_IMR: epu_dout = view.imr;
         MSR_IRR: epu_dout = view.irr;
         MSR_TSR: epu_dout = view.tsr;
         MSR_TCR: epu_dout = view.tcr;
         default: epu_dout = '0;
      endcase
   end

   assign epu_dout_valid = req.valid & ~flush & (req.op == OP_RMSR);

   // Only writes and exceptions go on to commit
   assign accept = req.valid & ~flush & (req.op != OP_RMSR);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         c_op <= OP_NONE;
         c_reg <= MSR_NONE;
      end
      else if (p_ce)
      begin
         c_op <= accept ? req.op : OP_NONE;
         c_reg <= dec_reg;
      end
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         c_wdat <= req.operand2;
         c_epc <= req.pc;
         c_nepc <= req.npc;
      end
   end

   assign commit = '{op: c_op, reg_sel: c_reg, wdat: c_wdat, epc: c_epc, nepc: c_nepc};

   assign wmsr_commit = p_ce & (c_op == OP_WMSR);
   assign wr.imr_we = wmsr_commit & (c_reg == MSR_IMR);
   assign wr.tsr_we = wmsr_commit & (c_reg == MSR_TSR);
   assign wr.tcr_we = wmsr_commit & (c_reg == MSR_TCR);
   assign wr.wdat = c_wdat;

   // A squashed request never reaches the commit stage
   a_flush_no_commit: assert property (@(posedge clk) disable iff (!rst_n)
      p_ce && flush |=> c_op == OP_NONE);

endmodule

// File: common/epu_pkg.sv
package epu_pkg;

   localparam int DW = 32;
   localparam int PC_W = 30;
   localparam int PSR_DW = 10;
   localparam int NUM_IRQ = 8;

   // MSR address is {bank, one-hot offset}
   localparam int MSR_BANK_AW = 4;
   localparam int MSR_BANK_OFF_AW = 9;
   localparam logic [MSR_BANK_AW-1:0] BANK_PS = 4'd0;
   localparam logic [MSR_BANK_AW-1:0] BANK_IRQC = 4'd6;
   localparam logic [MSR_BANK_AW-1:0] BANK_TSC = 4'd7;

   localparam int OFF_PSR = 0;
   localparam int OFF_CPUID = 1;
   localparam int OFF_EPSR = 2;
   localparam int OFF_EPC = 3;
   localparam int OFF_ELSA = 4;
   localparam int OFF_IMR = 0;
   localparam int OFF_IRR = 1;
   localparam int OFF_TSR = 0;
   localparam int OFF_TCR = 1;

   localparam logic [DW-1:0] CPUID_VALUE = 32'h0001_0a32;
   localparam logic [PSR_DW-1:0] PSR_RESET = 10'b00_0001_0000;

   // Byte addresses, always word aligned
   localparam logic [DW-1:0] VEC_SYSCALL = 32'h0000_0100;
   localparam logic [DW-1:0] VEC_INSN = 32'h0000_0200;
   localparam logic [DW-1:0] VEC_IRQ = 32'h0000_0300;

   localparam int TCR_CNT_W = 28;
   localparam int TCR_EN_BIT = 28;
   localparam int TCR_IE_BIT = 29;
   localparam int TCR_P_BIT = 31;

   typedef enum logic [2:0] {
      OP_NONE,
      OP_RMSR,
      OP_WMSR,
      OP_ERET,
      OP_ESYSCALL,
      OP_EINSN,
      OP_EIRQ
   } epu_op_e;

   typedef enum logic [3:0] {
      MSR_NONE,
      MSR_PSR,
      MSR_CPUID,
      MSR_EPSR,
      MSR_EPC,
      MSR_ELSA,
      MSR_IMR,
      MSR_IRR,
      MSR_TSR,
      MSR_TCR
   } msr_reg_e;

   typedef struct packed {
      logic dce;
      logic ice;
      logic dmme;
      logic imme;
      logic ire;
      logic rm;
      logic [3:0] rsvd;
   } psr_t;

   typedef struct packed {
      logic valid;
      epu_op_e op;
      logic [PC_W-1:0] pc;
      logic [PC_W-1:0] npc;
      logic [DW-1:0] operand1;
      logic [DW-1:0] operand2;
      logic [DW-1:0] imm;
   } epu_req_t;

   typedef struct packed {
      epu_op_e op;
      msr_reg_e reg_sel;
      logic [DW-1:0] wdat;
      logic [PC_W-1:0] epc;
      logic [PC_W-1:0] nepc;
   } commit_t;

   typedef struct packed {
      logic [DW-1:0] psr;
      logic [DW-1:0] epsr;
      logic [DW-1:0] epc;
      logic [DW-1:0] elsa;
      logic [DW-1:0] imr;
      logic [DW-1:0] irr;
      logic [DW-1:0] tsr;
      logic [DW-1:0] tcr;
   } msr_view_t;

   typedef struct packed {
      logic imr_we;
      logic tsr_we;
      logic tcr_we;
      logic [DW-1:0] wdat;
   } msr_wr_t;

endpackage
